// File: all.f
hdl/audio_stream_pkg.sv
hdl/mii_word_assembler.sv
hdl/frame_ram.sv
hdl/playback_sequencer.sv
hdl/i2s_serializer.sv
hdl/eth_audio_top.sv
verification/i2s_capture.sv
verification/tb_eth_audio.sv

// File: verification/tb_eth_audio.sv
`timescale 1ns/1ps

module tb_eth_audio;
    import audio_stream_pkg::*;

    localparam int header_words = 13;
    localparam int sclk_div = 4;
    // cycle limits for the bounded waits
    localparam int rise_limit = 4;
    localparam int drain_limit = 4000;
    localparam int fall_limit = 600;
    localparam int lrclk_limit = 400;

    logic mainclk;
    logic rst;
    logic eth_rx_dv;
    nibble_t eth_rxd;
    logic sclk;
    logic lrclk;
    logic sdin;
    logic playing;

    logic cap_valid;
    logic cap_right;
    sample_t cap_data;

    // raw words of the frame being sent, first nibble in bits 3:0
    ram_word_t frame_words[$];
    // expected samples, left then right for each word
    sample_t exp_q[$];
    sample_t exp_head;
    // channel of the queue head, high for right
    logic exp_right;
    // first audio sample of the frame has been seen
    logic started;
    // ignore captures while a frame overwrites a running playback
    logic skip;
    // playing must stay low
    logic silent;
    int check_errors;
    int timeouts;
    int cap_count;

    eth_audio_top #(
        .header_words (header_words),
        .sclk_div     (sclk_div)
    ) dut0 (
        .mainclk   (mainclk),
        .rst       (rst),
        .eth_rx_dv (eth_rx_dv),
        .eth_rxd   (eth_rxd),
        .sclk      (sclk),
        .lrclk     (lrclk),
        .sdin      (sdin),
        .playing   (playing)
    );

    i2s_capture cap0 (
        .mainclk  (mainclk),
        .rst      (rst),
        .sclk     (sclk),
        .lrclk    (lrclk),
        .sdin     (sdin),
        .valid    (cap_valid),
        .right_ch (cap_right),
        .data     (cap_data)
    );

    initial mainclk = 1'b0;
    always #20 mainclk = ~mainclk;

    // word as stored: nibbles swapped inside each byte
    function automatic ram_word_t stored_word(input ram_word_t raw);
        ram_word_t w;
        for (int n = 0; n < 8; n++) begin
            w[4*n +: 4] = raw[4*(n ^ 1) +: 4];
        end
        return w;
    endfunction

    // lowest nibble of the half goes to the top, zero padding below
    function automatic sample_t sample_from(input logic [15:0] half);
        sample_t s;
        s = '0;
        for (int n = 0; n < 4; n++) begin
            s[sample_bits-1-4*n -: 4] = half[4*n +: 4];
        end
        return s;
    endfunction

    task automatic refresh_head();
        exp_head = (exp_q.size() > 0) ? exp_q[0] : '0;
        // pairs alternate left and right, an odd count leaves a right sample in front
        exp_right = (exp_q.size() % 2) == 1;
    endtask

    task automatic step();
        @(posedge mainclk);
        #2;
    endtask

    task automatic make_frame(input int nwords);
        ram_word_t r;
        frame_words.delete();
        for (int k = 0; k < nwords; k++) begin
            r = $urandom();
            // no all-zero sample, so the start of audio is visible
            if (r[15:0] == '0) begin
                r[0] = 1'b1;
            end
            if (r[31:16] == '0) begin
                r[16] = 1'b1;
            end
            frame_words.push_back(r);
        end
    endtask

    task automatic load_expected();
        ram_word_t w;
        exp_q.delete();
        for (int k = header_words; k < frame_words.size(); k++) begin
            w = stored_word(frame_words[k]);
            exp_q.push_back(sample_from(w[15:0]));
            exp_q.push_back(sample_from(w[31:16]));
        end
        started = 1'b0;
        refresh_head();
    endtask

    // one nibble per cycle, then valid low
    task automatic send_frame(input int extra_nibs);
        foreach (frame_words[k]) begin
            for (int n = 0; n < 8; n++) begin
                eth_rx_dv = 1'b1;
                eth_rxd = frame_words[k][4*n +: 4];
                step();
            end
        end
        repeat (extra_nibs) begin
            eth_rx_dv = 1'b1;
            eth_rxd = nibble_t'($urandom());
            step();
        end
        eth_rx_dv = 1'b0;
        eth_rxd = '0;
    endtask

    task automatic wait_playing(input logic level, input int limit);
        int n;
        n = 0;
        while (playing !== level && n < limit) begin
            step();
            n++;
        end
        if (playing !== level) begin
            $display("ERROR: playing did not go to %0b within %0d cycles", level, limit);
            timeouts++;
        end
    endtask

    task automatic wait_queue(input int max_left, input int limit);
        int n;
        n = 0;
        while (exp_q.size() > max_left && n < limit) begin
            step();
            n++;
        end
        if (exp_q.size() > max_left) begin
            $display("ERROR: %0d expected samples still not played after %0d cycles",
                     exp_q.size(), limit);
            timeouts++;
        end
    endtask

    task automatic wait_lrclk_fall();
        int n;
        logic prev;
        logic fell;
        n = 0;
        prev = lrclk;
        fell = 1'b0;
        while (!fell && n < lrclk_limit) begin
            step();
            n++;
            fell = prev && !lrclk;
            prev = lrclk;
        end
        if (!fell) begin
            $display("ERROR: no lrclk falling edge within %0d cycles", lrclk_limit);
            timeouts++;
        end
    endtask

    task automatic play_frame(input int nwords, input int extra_nibs);
        make_frame(nwords);
        load_expected();
        send_frame(extra_nibs);
        wait_playing(1'b1, rise_limit);
        wait_queue(0, drain_limit);
        wait_playing(1'b0, fall_limit);
        // trailing silence
        repeat (2) wait_lrclk_fall();
    endtask

    // consume the queue head once audio has started
    always @(posedge mainclk) begin
        if (!rst && cap_valid && !skip) begin
            cap_count++;
            if (exp_q.size() > 0 && (started || cap_data != '0)) begin
                started = 1'b1;
                void'(exp_q.pop_front());
                refresh_head();
            end
        end
    end

    // all outputs low while in reset
    assert property (@(negedge mainclk)
        rst |-> (!playing && !sclk && !lrclk && !sdin))
        else begin
            $display("CHECK FAILED t=%0t {playing,sclk,lrclk,sdin} expected 0000 got %b%b%b%b",
                     $time, playing, sclk, lrclk, sdin);
            check_errors++;
        end

    // zero before audio starts, otherwise the next expected sample
    assert property (@(negedge mainclk) disable iff (rst)
        (cap_valid && !skip) |-> (cap_data == exp_head || (!started && cap_data == '0)))
        else begin
            $display("CHECK FAILED t=%0t %s_sample expected %h got %h", $time,
                     cap_right ? "right" : "left", exp_head, cap_data);
            check_errors++;
        end

    // left samples travel with lrclk low
    assert property (@(negedge mainclk) disable iff (rst)
        (cap_valid && !skip && exp_head != '0 && (started || cap_data != '0))
            |-> (cap_right == exp_right))
        else begin
            $display("CHECK FAILED t=%0t cap_right expected %b got %b", $time,
                     exp_right, cap_right);
            check_errors++;
        end

    assert property (@(negedge mainclk) disable iff (rst)
        cap_valid |-> (cap_data[sample_pad_bits-1:0] == '0))
        else begin
            $display("CHECK FAILED t=%0t cap_data[%0d:0] expected %h got %h", $time,
                     sample_pad_bits - 1, {sample_pad_bits{1'b0}},
                     cap_data[sample_pad_bits-1:0]);
            check_errors++;
        end

    assert property (@(negedge mainclk) disable iff (rst)
        silent |-> !playing)
        else begin
            $display("CHECK FAILED t=%0t playing expected 0 got %b", $time, playing);
            check_errors++;
        end

    initial begin
        void'($urandom(54321));
        rst = 1'b1;
        eth_rx_dv = 1'b0;
        eth_rxd = '0;
        started = 1'b0;
        skip = 1'b0;
        silent = 1'b0;
        exp_head = '0;
        exp_right = 1'b0;
        check_errors = 0;
        timeouts = 0;
        cap_count = 0;
        repeat (8) @(posedge mainclk);
        #2;
        rst = 1'b0;

        // idle output is silence
        repeat (3) wait_lrclk_fall();

        play_frame(20, 0);
        // partial trailing word dropped
        play_frame(20, 3);

        // too short to get past the header
        silent = 1'b1;
        make_frame(10);
        load_expected();
        send_frame(0);
        repeat (4) wait_lrclk_fall();
        silent = 1'b0;

        // second frame lands while the first one plays
        make_frame(20);
        load_expected();
        send_frame(0);
        wait_playing(1'b1, rise_limit);
        wait_queue(exp_q.size() - 4, drain_limit);
        skip = 1'b1;
        make_frame(20);
        send_frame(0);
        repeat (3) step();
        // pair in flight at the frame end is mixed content
        wait_lrclk_fall();
        load_expected();
        skip = 1'b0;
        wait_queue(0, drain_limit);
        wait_playing(1'b0, fall_limit);
        repeat (2) wait_lrclk_fall();

        assert (cap_count > 0)
            else begin
                $display("ERROR: no samples were captured from the I2S output");
                check_errors++;
            end

        $display("summary: %0d check errors, %0d timeouts, %0d samples captured",
                 check_errors, timeouts, cap_count);
        if (check_errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: verification/i2s_capture.sv
`timescale 1ns/1ps

module i2s_capture (
    input  logic mainclk,
    input  logic rst,
    input  logic sclk,
    input  logic lrclk,
    input  logic sdin,
    output logic valid,
    output logic right_ch,
    output audio_stream_pkg::sample_t data
);
    import audio_stream_pkg::*;

    logic sclk_q;
    logic lr_q;
    // set once a word clock edge has been seen
    logic synced;
    // slot index inside the current half, 0 is the delay slot
    logic [5:0] slot;
    logic [5:0] slot_next;
    sample_t shreg;
    logic sclk_edge;
    logic same_half;

    // receiver samples sdin on sclk rising edges
    assign sclk_edge = sclk && !sclk_q;
    assign same_half = (lrclk == lr_q);
    assign slot_next = slot + 6'd1;

    always_ff @(posedge mainclk) begin
        if (rst) begin
            sclk_q <= 1'b0;
            lr_q <= 1'b0;
            synced <= 1'b0;
            slot <= '0;
            shreg <= '0;
            valid <= 1'b0;
            right_ch <= 1'b0;
            data <= '0;
        end else begin
            sclk_q <= sclk;
            valid <= 1'b0;
            if (sclk_edge) begin
                lr_q <= lrclk;
                if (!same_half) begin
                    // one slot of i2s delay after the lrclk edge
                    slot <= '0;
                    synced <= 1'b1;
                end else begin
                    slot <= slot_next;
                    if (synced && (slot_next <= sample_bits)) begin
                        shreg <= {shreg[sample_bits-2:0], sdin};
                        // lsb of the 24-bit sample just arrived
                        if (slot_next == sample_bits) begin
                            valid <= 1'b1;
                            right_ch <= lrclk;
                            data <= {shreg[sample_bits-2:0], sdin};
                        end
                    end
                end
            end
        end
    end

endmodule

// File: hdl/eth_audio_top.sv
`timescale 1ns/1ps

module eth_audio_top #(
    parameter int header_words = 13,
    parameter int sclk_div = 4
) (
    input  logic mainclk,
    input  logic rst,
    input  logic eth_rx_dv,
    input  audio_stream_pkg::nibble_t eth_rxd,
    output logic sclk,
    output logic lrclk,
    output logic sdin,
    output logic playing
);
    import audio_stream_pkg::*;

    // receiver to buffer and sequencer
    ram_wr_t wr;
    frame_end_t frame_end;
    // sequencer read port
    logic rd_en;
    ram_addr_t rd_addr;
    ram_word_t rd_data;
    // sequencer to serializer handshake
    sample_pair_t samples;
    logic sample_req;

    mii_word_assembler asm0 (
        .mainclk   (mainclk),
        .rst       (rst),
        .eth_rx_dv (eth_rx_dv),
        .eth_rxd   (eth_rxd),
        .wr        (wr),
        .frame_end (frame_end)
    );

    frame_ram ram0 (
        .mainclk (mainclk),
        .wr      (wr),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    playback_sequencer #(
        .header_words (header_words)
    ) seq0 (
        .mainclk    (mainclk),
        .rst        (rst),
        .frame_end  (frame_end),
        .sample_req (sample_req),
        .rd_data    (rd_data),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .samples    (samples),
        .playing    (playing)
    );

    // bit and word clocks derived from mainclk
    i2s_serializer #(
        .sclk_div (sclk_div)
    ) ser0 (
        .mainclk    (mainclk),
        .rst        (rst),
        .samples    (samples),
        .sample_req (sample_req),
        .sclk       (sclk),
        .lrclk      (lrclk),
        .sdin       (sdin)
    );

endmodule

// File: hdl/i2s_serializer.sv
`timescale 1ns/1ps

module i2s_serializer #(
    parameter int sclk_div = 4
) (
    input  logic mainclk,
    input  logic rst,
    input  audio_stream_pkg::sample_pair_t samples,
    output logic sample_req,
    output logic sclk,
    output logic lrclk,
    output logic sdin
);
    import audio_stream_pkg::*;

    localparam int div_w = $clog2(sclk_div);
    localparam int half_div = sclk_div / 2;
    // zero slots after each sample inside its 32-slot half
    localparam int tail_bits = 32 - $bits(sample_t);

    logic [div_w-1:0] div_cnt;
    // slot index within the 64-slot frame, 0..31 is left
    logic [5:0] bit_cnt;
    logic [5:0] next_bit;
    logic [63:0] shreg;
    logic sclk_rise;
    logic sclk_fall;
    logic frame_load;
    // delays the request two cycles after lrclk rises
    logic [1:0] req_pipe;

    // edge enables from the divide counter
    assign sclk_rise = (div_cnt == div_w'(half_div - 1));
    assign sclk_fall = (div_cnt == div_w'(sclk_div - 1));
    assign next_bit = bit_cnt + 6'd1;
    // lrclk falling edge, start of a new frame
    assign frame_load = sclk_fall && (bit_cnt == 6'd63);

    always_ff @(posedge mainclk) begin
        if (rst) begin
            div_cnt <= '0;
            // first falling edge after reset loads a frame
            bit_cnt <= '1;
            sclk <= 1'b0;
            lrclk <= 1'b0;
            sdin <= 1'b0;
            req_pipe <= '0;
            sample_req <= 1'b0;
        end else begin
            req_pipe <= {req_pipe[0], sclk_fall && (bit_cnt == 6'd31)};
            sample_req <= req_pipe[1];
            if (sclk_fall) begin
                div_cnt <= '0;
                sclk <= 1'b0;
                bit_cnt <= next_bit;
                lrclk <= next_bit[5];
                // one slot of delay, the slot at the lrclk edge is zero
                if (frame_load) begin
                    sdin <= 1'b0;
                end else begin
                    sdin <= shreg[63];
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
                if (sclk_rise) begin
                    sclk <= 1'b1;
                end
            end
        end
    end

    // msb first, left half then right half
    always_ff @(posedge mainclk) begin
        if (frame_load) begin
            shreg <= {samples.left, {tail_bits{1'b0}},
                      samples.right, {tail_bits{1'b0}}};
        end else if (sclk_fall) begin
            shreg <= {shreg[62:0], 1'b0};
        end
    end

    // word clock moves together with sclk going low
    assert property (@(posedge mainclk) disable iff (rst)
        $changed(lrclk) |-> $fell(sclk))
        else $error("lrclk moved off a sclk falling edge");

    assert property (@(posedge mainclk) disable iff (rst)
        sample_req |=> !sample_req)
        else $error("sample_req longer than one cycle");

endmodule

// File: hdl/playback_sequencer.sv
`timescale 1ns/1ps

module playback_sequencer #(
    parameter int header_words = 13
) (
    input  logic mainclk,
    input  logic rst,
    input  audio_stream_pkg::frame_end_t frame_end,
    input  logic sample_req,
    input  audio_stream_pkg::ram_word_t rd_data,
    output logic rd_en,
    output audio_stream_pkg::ram_addr_t rd_addr,
    output audio_stream_pkg::sample_pair_t samples,
    output logic playing
);
    import audio_stream_pkg::*;

    // first word after the packet header
    localparam ram_addr_t first_addr = ram_addr_t'(header_words);

    play_state_t state;
    ram_addr_t end_addr;
    // word at end_addr already handed out
    logic last_sent;
    logic frame_ok;

    // 16-bit half in reversed nibble order, padded below
    function automatic sample_t build_sample(input logic [15:0] half);
        return {half[3:0], half[7:4], half[11:8], half[15:12],
                {sample_pad_bits{1'b0}}};
    endfunction

    // frame long enough to hold audio past the header
    assign frame_ok = frame_end.any_word && (int'(frame_end.last_addr) >= header_words);

    // read straight away on a request, data lands in PLAY_FETCH
    assign rd_en = (state == PLAY_HOLD) && sample_req && !last_sent;

    assign playing = (state != PLAY_IDLE);

    always_ff @(posedge mainclk) begin
        if (rst) begin
            state <= PLAY_IDLE;
            last_sent <= 1'b0;
            rd_addr <= first_addr;
            end_addr <= first_addr;
            samples <= '0;
        end else if (frame_end.done) begin
            // new frame, restart from the header offset
            last_sent <= 1'b0;
            rd_addr <= first_addr;
            end_addr <= frame_end.last_addr;
            samples <= '0;
            if (frame_ok) begin
                state <= PLAY_HOLD;
            end else begin
                state <= PLAY_IDLE;
            end
        end else begin
            case (state)
                PLAY_HOLD: begin
                    if (sample_req && last_sent) begin
                        // frame exhausted, go silent
                        samples <= '0;
                        state <= PLAY_IDLE;
                    end else if (rd_en) begin
                        state <= PLAY_FETCH;
                    end
                end
                PLAY_FETCH: begin
                    samples.left <= build_sample(rd_data[15:0]);
                    samples.right <= build_sample(rd_data[31:16]);
                    if (rd_addr == end_addr) begin
                        last_sent <= 1'b1;
                    end else begin
                        rd_addr <= rd_addr + 1'b1;
                    end
                    state <= PLAY_HOLD;
                end
                PLAY_IDLE: begin
                    samples <= '0;
                end
                default: begin
                    state <= PLAY_IDLE;
                end
            endcase
        end
    end

    // reads stay inside the stored frame
    assert property (@(posedge mainclk) disable iff (rst)
        playing |-> (rd_addr <= end_addr))
        else $error("read address %0d past end %0d", rd_addr, end_addr);

endmodule

// File: hdl/frame_ram.sv
`timescale 1ns/1ps

module frame_ram (
    input  logic mainclk,
    input  audio_stream_pkg::ram_wr_t wr,
    input  logic rd_en,
    input  audio_stream_pkg::ram_addr_t rd_addr,
    output audio_stream_pkg::ram_word_t rd_data
);
    import audio_stream_pkg::*;

    // one frame of received words
    ram_word_t mem [ram_depth];

    // write port, fed straight from the receiver
    always_ff @(posedge mainclk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read, data valid the cycle after rd_en
    always_ff @(posedge mainclk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // read address driven whenever a read is issued
    assert property (@(posedge mainclk)
        rd_en |-> !$isunknown(rd_addr))
        else $error("ram read with unknown address");

endmodule

// File: hdl/mii_word_assembler.sv
`timescale 1ns/1ps

module mii_word_assembler (
    input  logic mainclk,
    input  logic rst,
    input  logic eth_rx_dv,
    input  audio_stream_pkg::nibble_t eth_rxd,
    output audio_stream_pkg::ram_wr_t wr,
    output audio_stream_pkg::frame_end_t frame_end
);
    import audio_stream_pkg::*;

    // one extra bit so a full buffer differs from an empty one
    logic [ram_addr_bits:0] word_cnt;
    logic [2:0] nib_cnt;
    ram_word_t shreg;
    ram_word_t next_word;
    logic dv_q;
    logic word_done;
    logic frame_close;

    // registered outputs
    logic wr_en;
    ram_addr_t wr_addr;
    ram_word_t wr_data;
    logic done_q;
    ram_addr_t last_addr_q;
    logic any_word_q;

    // swap the two nibbles of every byte
    function automatic ram_word_t swap_pairs(input ram_word_t w);
        ram_word_t s;
        for (int b = 0; b < word_bits / 8; b++) begin
            s[8*b +: 4] = w[8*b+4 +: 4];
            s[8*b+4 +: 4] = w[8*b +: 4];
        end
        return s;
    endfunction

    // newest nibble enters at the top, first one ends up in bits 3:0
    assign next_word = {eth_rxd, shreg[word_bits-1:nibble_bits]};
    assign word_done = eth_rx_dv && (nib_cnt == 3'd7);
    // valid dropped after being high
    assign frame_close = !eth_rx_dv && dv_q;

    always_ff @(posedge mainclk) begin
        if (rst) begin
            nib_cnt <= '0;
            word_cnt <= '0;
            dv_q <= 1'b0;
            wr_en <= 1'b0;
            done_q <= 1'b0;
        end else begin
            dv_q <= eth_rx_dv;
            wr_en <= word_done;
            done_q <= frame_close;
            if (eth_rx_dv) begin
                nib_cnt <= nib_cnt + 3'd1;
                if (word_done) begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end else if (frame_close) begin
                // next frame starts again at address 0
                nib_cnt <= '0;
                word_cnt <= '0;
            end
        end
    end

    // data side
    always_ff @(posedge mainclk) begin
        if (eth_rx_dv) begin
            shreg <= next_word;
        end
        if (word_done) begin
            wr_addr <= word_cnt[ram_addr_bits-1:0];
            wr_data <= swap_pairs(next_word);
        end
        if (frame_close) begin
            // partial trailing nibbles are simply dropped
            last_addr_q <= ram_addr_t'(word_cnt - 1'b1);
            any_word_q <= (word_cnt != '0);
        end
    end

    assign wr = '{en: wr_en, addr: wr_addr, data: wr_data};
    assign frame_end = '{done: done_q, last_addr: last_addr_q, any_word: any_word_q};

    // frame must fit the buffer
    assert property (@(posedge mainclk) disable iff (rst)
        word_done |-> (word_cnt < ram_depth))
        else $error("frame longer than %0d words", ram_depth);

    // close report and last write stay apart
    assert property (@(posedge mainclk) disable iff (rst)
        !(wr_en && done_q))
        else $error("frame end overlaps a ram write");

endmodule

// File: hdl/audio_stream_pkg.sv
package audio_stream_pkg;

    // frame buffer geometry
    localparam int ram_depth = 512;
    localparam int ram_addr_bits = $clog2(ram_depth);

    // payload widths
    localparam int word_bits = 32;
    localparam int nibble_bits = 4;
    localparam int sample_bits = 24;
    // zero bits below the 16-bit payload of each sample
    localparam int sample_pad_bits = 8;

    typedef logic [ram_addr_bits-1:0] ram_addr_t;
    typedef logic [word_bits-1:0] ram_word_t;
    typedef logic [nibble_bits-1:0] nibble_t;
    typedef logic [sample_bits-1:0] sample_t;

    // one write into the frame buffer
    typedef struct packed {
        logic en;
        ram_addr_t addr;
        ram_word_t data;
    } ram_wr_t;

    // frame close report from the receiver
    typedef struct packed {
        logic done;
        ram_addr_t last_addr;
        logic any_word;
    } frame_end_t;

    // one stereo frame worth of audio
    typedef struct packed {
        sample_t left;
        sample_t right;
    } sample_pair_t;

    typedef enum logic [1:0] {
        PLAY_IDLE,
        PLAY_FETCH,
        PLAY_HOLD
    } play_state_t;

endpackage
